// File: list.f
common/immDecodePkg.sv
logic/bundleSplitter.sv
immGen/immLane.sv
logic/bundleCollector.sv
logic/immDecodeTop.sv
testbench/clockGen.sv
testbench/immDecodeTop_sva.sv
testbench/immDecodeTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the immediate-decode testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=immDecodeSim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module immDecodeTb \
    -f list.f \
    --Mdir "${BUILD_DIR}" -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
simStatus=$?
cat "${LOG_FILE}"
if [ ${simStatus} -ne 0 ]; then
    echo "Simulation exited with status ${simStatus}"
    exit 1
fi

if grep -Fxq "=== PASS ===" "${LOG_FILE}"; then
    exit 0
fi
echo "Pass line not found in ${LOG_FILE}"
exit 1

// File: testbench/immDecodeTb.sv
module immDecodeTb;
    import immDecodePkg::*;

    // Expected top-level outputs for one bundle.
    typedef struct packed {
        logic                   valid;
        logic [CountWidth-1:0]  count;
        laneOutT [NumLanes-1:0] slots;
    } expectT;

    localparam logic [31:0] Seed = 32'd96742;
    localparam int DriveDelay = 2;
    localparam int Latency = 3;

    // Cycles per test.
    localparam int PlainCycles = 60;
    localparam int AdjustCycles = 60;
    localparam int FallbackCycles = 40;
    localparam int CompactCycles = 80;
    localparam int StreamCycles = 400;
    localparam int CycleLimit = 8 + PlainCycles + AdjustCycles + FallbackCycles
                              + CompactCycles + StreamCycles + 5 * Latency + 50;

    // Stimulus modes.
    localparam int ModeIdle = 0;
    localparam int ModePlain = 1;
    localparam int ModeAdjust = 2;
    localparam int ModeFallback = 3;
    localparam int ModeCompact = 4;
    localparam int ModeStream = 5;

    logic clk;
    logic rstN;
    logic bundleValid;
    logic [NumLanes-1:0] slotValid;
    logic [NumLanes-1:0][InstrWidth-1:0] bundle;
    logic outValid;
    logic [CountWidth-1:0] outCount;
    laneOutT [NumLanes-1:0] outSlots;

    logic [31:0] lfsrState;
    expectT expectQ[$];
    int errorCount;
    int checkCount;
    int testCount;
    int cycleCount;

    clockGen u_clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    immDecodeTop u_immDecodeTop (
        .clk         (clk),
        .rstN        (rstN),
        .bundleValid (bundleValid),
        .slotValid   (slotValid),
        .bundle      (bundle),
        .outValid    (outValid),
        .outCount    (outCount),
        .outSlots    (outSlots)
    );

    // Galois LFSR, shifting right.
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hD0000001;
        end else begin
            return s >> 1;
        end
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic logic isKnownOpcode(input logic [6:0] op);
        return op inside {opLoad, opStore, opBranch, opJal, opJalr,
                          opAuipc, opLui, opFlw, opFsw};
    endfunction

    // Plain formats first, then the pc-relative three.
    function automatic logic [6:0] tableOpcode(input int idx);
        case (idx)
            0: return opLoad;
            1: return opStore;
            2: return opJalr;
            3: return opLui;
            4: return opFlw;
            5: return opFsw;
            6: return opBranch;
            7: return opJal;
            default: return opAuipc;
        endcase
    endfunction

    function automatic logic [31:0] makeInstr(input int mode);
        logic [31:0] tmp;
        logic [6:0] op;
        logic [24:0] upper;
        tmp = randBits(25);
        upper = tmp[24:0];
        if (mode == ModePlain) begin
            tmp = randBits(3);
            op = tableOpcode(int'(tmp % 6));
        end else if (mode == ModeAdjust) begin
            tmp = randBits(2);
            op = tableOpcode(6 + int'(tmp % 3));
            // Zero, all ones and small fields hit the wrap near zero.
            tmp = randBits(2);
            if (tmp[1:0] == 2'd0) begin
                upper = '0;
            end else if (tmp[1:0] == 2'd1) begin
                upper = '1;
            end else if (tmp[1:0] == 2'd2) begin
                tmp = randBits(8);
                upper = {17'b0, tmp[7:0]};
            end
        end else if (mode == ModeFallback) begin
            tmp = randBits(7);
            while (isKnownOpcode(tmp[6:0])) begin
                tmp = randBits(7);
            end
            op = tmp[6:0];
        end else begin
            // Weighted pick, 9 of 16 known opcodes.
            tmp = randBits(4);
            if (tmp < 9) begin
                op = tableOpcode(int'(tmp));
            end else begin
                tmp = randBits(7);
                op = tmp[6:0];
            end
        end
        return {upper, op};
    endfunction

    // Reference immediate for one valid instruction.
    function automatic laneOutT expectedLane(input logic [31:0] instr);
        logic signed [11:0] iField;
        logic signed [11:0] sField;
        logic signed [12:0] bField;
        logic signed [20:0] jField;
        logic signed [31:0] uField;
        longint val;
        laneOutT r;
        iField = instr[31:20];
        sField = {instr[31:25], instr[11:7]};
        bField = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        jField = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        uField = {instr[31:12], 12'h000};
        r.valid = 1'b1;
        r.kind = kindI;
        val = 64'(iField);
        case (instr[6:0])
            opStore: begin r.kind = kindS; val = 64'(sField); end
            opFsw: begin r.kind = kindFsw; val = 64'(sField); end
            opJalr: begin r.kind = kindJalr; val = 64'(iField); end
            opFlw: begin r.kind = kindFlw; val = 64'(iField); end
            opLui: begin r.kind = kindLui; val = 64'(uField); end
            // Pc already points at the next instruction.
            opBranch: begin r.kind = kindB; val = 64'(bField) - 64'sd4; end
            opJal: begin r.kind = kindJ; val = 64'(jField) - 64'sd4; end
            opAuipc: begin r.kind = kindAuipc; val = 64'(uField) - 64'sd4; end
            default: ;
        endcase
        r.imm = val;
        return r;
    endfunction

    // Valid lanes packed low, in lane order.
    function automatic expectT computeExpected(input logic bv, input logic [NumLanes-1:0] mask,
                                               input logic [NumLanes-1:0][31:0] instrs);
        expectT e;
        int n;
        e = '0;
        n = 0;
        for (int i = 0; i < NumLanes; i++) begin
            if (bv && mask[i]) begin
                e.slots[n] = expectedLane(instrs[i]);
                n++;
            end
        end
        e.count = CountWidth'(n);
        e.valid = (n != 0);
        return e;
    endfunction

    task automatic reportMismatch(input string name, input logic [63:0] expVal,
                                  input logic [63:0] actVal);
        $display("FAIL %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
        errorCount++;
    endtask

    task automatic checkResetState();
        if (outValid !== 1'b0) reportMismatch("outValid", 64'h0, 64'(outValid));
        if (outCount !== '0) reportMismatch("outCount", 64'h0, 64'(outCount));
        for (int i = 0; i < NumLanes; i++) begin
            if (outSlots[i].valid !== 1'b0) begin
                reportMismatch($sformatf("outSlots[%0d].valid", i), 64'h0,
                               64'(outSlots[i].valid));
            end
        end
        checkCount++;
    endtask

    // Oldest expectation against the current outputs.
    task automatic checkOutputs();
        expectT e;
        e = expectQ.pop_front();
        checkCount++;
        if (outValid !== e.valid) reportMismatch("outValid", 64'(e.valid), 64'(outValid));
        if (outCount !== e.count) reportMismatch("outCount", 64'(e.count), 64'(outCount));
        for (int i = 0; i < NumLanes; i++) begin
            if (outSlots[i].valid !== e.slots[i].valid) begin
                reportMismatch($sformatf("outSlots[%0d].valid", i),
                               64'(e.slots[i].valid), 64'(outSlots[i].valid));
            end
            if (outSlots[i].kind !== e.slots[i].kind) begin
                reportMismatch($sformatf("outSlots[%0d].kind", i),
                               64'(e.slots[i].kind), 64'(outSlots[i].kind));
            end
            if (outSlots[i].imm !== e.slots[i].imm) begin
                reportMismatch($sformatf("outSlots[%0d].imm", i),
                               e.slots[i].imm, outSlots[i].imm);
            end
        end
    endtask

    task automatic driveAndExpect(input int mode);
        logic bv;
        logic [NumLanes-1:0] mask;
        logic [NumLanes-1:0][31:0] instrs;
        logic [31:0] tmp;
        for (int i = 0; i < NumLanes; i++) begin
            instrs[i] = makeInstr(mode);
        end
        bv = 1'b1;
        mask = '1;
        if (mode == ModeIdle) begin
            bv = 1'b0;
            mask = '0;
        end else if (mode == ModeCompact) begin
            // Empty and full masks get a quarter each.
            tmp = randBits(2);
            if (tmp[1:0] == 2'd0) begin
                mask = '0;
            end else if (tmp[1:0] != 2'd1) begin
                tmp = randBits(4);
                mask = tmp[NumLanes-1:0];
            end
            bv = (randBits(3) != 0);
        end else if (mode == ModeStream) begin
            tmp = randBits(4);
            mask = tmp[NumLanes-1:0];
            bv = (randBits(3) != 0);
        end
        bundleValid = bv;
        slotValid = mask;
        bundle = instrs;
        expectQ.push_back(computeExpected(bv, mask, instrs));
    endtask

    // Idle tail drains the pipe inside the test.
    task automatic runTest(input string name, input int mode, input int cycles);
        int errorsBefore;
        int checksBefore;
        errorsBefore = errorCount;
        checksBefore = checkCount;
        for (int c = 0; c < cycles + Latency; c++) begin
            checkOutputs();
            driveAndExpect((c < cycles) ? mode : ModeIdle);
            @(posedge clk);
            #DriveDelay;
        end
        testCount++;
        $display("test %-9s %0d checks, %0d errors", name,
                 checkCount - checksBefore, errorCount - errorsBefore);
    endtask

    // Hang guard.
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("Timeout: run went past %0d cycles", CycleLimit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        lfsrState = Seed;
        bundleValid = 1'b0;
        slotValid = '0;
        bundle = '0;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        cycleCount = 0;

        // Reset registers load on the first edge.
        @(posedge clk);
        #DriveDelay;
        while (!rstN) begin
            checkResetState();
            @(posedge clk);
            #DriveDelay;
        end
        testCount++;
        $display("test %-9s %0d checks, %0d errors", "reset", checkCount, errorCount);

        // Pipe holds only reset bundles.
        for (int i = 0; i < Latency; i++) begin
            expectQ.push_back('0);
        end

        runTest("plain", ModePlain, PlainCycles);
        runTest("adjust", ModeAdjust, AdjustCycles);
        runTest("fallback", ModeFallback, FallbackCycles);
        runTest("compact", ModeCompact, CompactCycles);
        runTest("stream", ModeStream, StreamCycles);

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: testbench/immDecodeTop_sva.sv
module immDecodeTopSva (
    input  logic                                               clk,
    input  logic                                               rstN,
    input  logic                                               outValid,
    input  logic [immDecodePkg::CountWidth-1:0]                outCount,
    input  immDecodePkg::laneOutT [immDecodePkg::NumLanes-1:0] outSlots
);
    import immDecodePkg::*;

    // Output stays empty through reset.
    resetQuiet: assert property (@(posedge clk) !rstN |=> !outValid)
        else $error("outValid high after a reset cycle");

    // Never more filled slots than lanes.
    countInRange: assert property (@(posedge clk) disable iff (!rstN)
        outCount <= CountWidth'(NumLanes))
        else $error("outCount above lane count");

    // outValid is just a non-zero count.
    validMatchesCount: assert property (@(posedge clk) disable iff (!rstN)
        outValid == (outCount != '0))
        else $error("outValid disagrees with outCount");

    // Slots past the count carry nothing.
    for (genvar i = 0; i < NumLanes; i++) begin : gSlot
        slotAboveCount: assert property (@(posedge clk) disable iff (!rstN)
            (CountWidth'(i) >= outCount) |-> !outSlots[i].valid)
            else $error("slot %0d valid at or above outCount", i);
    end

endmodule

bind immDecodeTop immDecodeTopSva u_immDecodeTopSva (
    .clk      (clk),
    .rstN     (rstN),
    .outValid (outValid),
    .outCount (outCount),
    .outSlots (outSlots)
);

// File: testbench/clockGen.sv
module clockGen #(
    parameter int HalfPeriod   = 5,
    parameter int ResetCycles  = 8,
    parameter int ReleaseDelay = 1
) (
    output logic clk,
    output logic rstN
);

    // Free-running clock, 10 time units per period.
    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // Reset low across the first ResetCycles rising edges.
    // Released just after an edge, away from the sampling point.
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #ReleaseDelay;
        rstN = 1'b1;
    end

endmodule

// File: logic/immDecodeTop.sv
module immDecodeTop (
    input  logic                                                            clk,
    input  logic                                                            rstN,
    input  logic                                                            bundleValid,
    input  logic [immDecodePkg::NumLanes-1:0]                               slotValid,
    input  logic [immDecodePkg::NumLanes-1:0][immDecodePkg::InstrWidth-1:0] bundle,
    output logic                                                            outValid,
    output logic [immDecodePkg::CountWidth-1:0]                             outCount,
    output immDecodePkg::laneOutT [immDecodePkg::NumLanes-1:0]              outSlots
);
    import immDecodePkg::*;

    // Registered lane records from the splitter.
    laneInT [NumLanes-1:0] laneIn;

    // Registered lane results.
    laneOutT [NumLanes-1:0] laneOut;

    // Stage 1, register and fan out the bundle.
    bundleSplitter u_bundleSplitter (
        .clk         (clk),
        .rstN        (rstN),
        .bundleValid (bundleValid),
        .slotValid   (slotValid),
        .bundle      (bundle),
        .laneIn      (laneIn)
    );

    // Stage 2, one immediate decoder per slot.
    for (genvar i = 0; i < NumLanes; i++) begin : gLane
        immLane u_immLane (
            .clk     (clk),
            .rstN    (rstN),
            .laneIn  (laneIn[i]),
            .laneOut (laneOut[i])
        );
    end

    // Stage 3, compact and count.
    bundleCollector u_bundleCollector (
        .clk      (clk),
        .rstN     (rstN),
        .laneOut  (laneOut),
        .outValid (outValid),
        .outCount (outCount),
        .outSlots (outSlots)
    );

endmodule

// File: logic/bundleCollector.sv
module bundleCollector (
    input  logic                                              clk,
    input  logic                                              rstN,
    input  immDecodePkg::laneOutT [immDecodePkg::NumLanes-1:0] laneOut,
    output logic                                              outValid,
    output logic [immDecodePkg::CountWidth-1:0]               outCount,
    output immDecodePkg::laneOutT [immDecodePkg::NumLanes-1:0] outSlots
);
    import immDecodePkg::*;

    // Compacted slots, lowest index first.
    laneOutT [NumLanes-1:0] packedSlots;

    // Number of valid lanes this cycle.
    logic [CountWidth-1:0] fillCount;

    // Any lane valid at all.
    logic anyValid;

    // Compaction.
    // Lanes are walked in program order.
    // Each valid result lands in the next free slot.
    // Slots past the count stay all zero.
    always_comb begin
        packedSlots = '0;
        fillCount   = '0;
        for (int i = 0; i < NumLanes; i++) begin
            if (laneOut[i].valid) begin
                packedSlots[fillCount] = laneOut[i];
                fillCount              = fillCount + 1'b1;
            end
        end
    end

    // Empty bundles produce no output.
    assign anyValid = (fillCount != '0);

    // Output register.
    // Reset drops outValid, the count and every slot valid.
    // Slot kind and imm load from the compacted slots on every edge.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
            outCount <= '0;
            for (int i = 0; i < NumLanes; i++) begin
                outSlots[i].valid <= 1'b0;
                outSlots[i].kind  <= packedSlots[i].kind;
                outSlots[i].imm   <= packedSlots[i].imm;
            end
        end else begin
            outValid <= anyValid;
            outCount <= fillCount;
            outSlots <= packedSlots;
        end
    end

endmodule

// File: immGen/immLane.sv
module immLane (
    input  logic                  clk,
    input  logic                  rstN,
    input  immDecodePkg::laneInT  laneIn,
    output immDecodePkg::laneOutT laneOut
);
    import immDecodePkg::*;

    // Opcode field of the lane's instruction.
    logic [OpcodeWidth-1:0] opcode;

    // Decoded format.
    immKindT kind;

    // Sign-extended field layouts, one per format family.
    logic [XLen-1:0] immI;
    logic [XLen-1:0] immS;
    logic [XLen-1:0] immB;
    logic [XLen-1:0] immJ;
    logic [XLen-1:0] immU;

    // Selected immediate before and after the pc correction.
    logic [XLen-1:0] immSel;
    logic [XLen-1:0] immAdj;

    // Set for formats that see an already advanced pc.
    logic needsAdjust;

    // Next-cycle lane result.
    laneOutT laneNext;

    assign opcode = laneIn.instr[OpcodeWidth-1:0];

    // Opcode classification.
    // Exact match only; anything unknown falls back to I.
    always_comb begin
        case (opcode)
            opLoad:   kind = kindI;
            opStore:  kind = kindS;
            opBranch: kind = kindB;
            opJal:    kind = kindJ;
            opJalr:   kind = kindJalr;
            opAuipc:  kind = kindAuipc;
            opLui:    kind = kindLui;
            opFlw:    kind = kindFlw;
            opFsw:    kind = kindFsw;
            default:  kind = kindI;
        endcase
    end

    // I layout, shared by jalr and flw.
    assign immI = {{(XLen - 12){laneIn.instr[31]}}, laneIn.instr[31:20]};

    // S layout, shared by fsw.
    assign immS = {{(XLen - 12){laneIn.instr[31]}},
                   laneIn.instr[31:25], laneIn.instr[11:7]};

    // B layout.
    // Offset is in halfwords, hence the zero at the bottom.
    assign immB = {{(XLen - 13){laneIn.instr[31]}},
                   laneIn.instr[31], laneIn.instr[7],
                   laneIn.instr[30:25], laneIn.instr[11:8], 1'b0};

    // J layout, same halfword scaling.
    assign immJ = {{(XLen - 21){laneIn.instr[31]}},
                   laneIn.instr[31], laneIn.instr[19:12],
                   laneIn.instr[20], laneIn.instr[30:21], 1'b0};

    // U layout for lui and auipc.
    // Upper 20 bits, low 12 zero, extended from bit 31 for RV64.
    assign immU = {{(XLen - 32){laneIn.instr[31]}},
                   laneIn.instr[31:12], 12'b0};

    // Format select.
    always_comb begin
        case (kind)
            kindI, kindJalr, kindFlw: immSel = immI;
            kindS, kindFsw:           immSel = immS;
            kindB:                    immSel = immB;
            kindJ:                    immSel = immJ;
            kindAuipc, kindLui:       immSel = immU;
            default:                  immSel = immI;
        endcase
    end

    // Pc-relative formats.
    // The pc has moved one instruction on by the time it is added.
    assign needsAdjust = (kind == kindB) || (kind == kindJ) || (kind == kindAuipc);

    // Minus 4 wraps modulo 2^XLen.
    assign immAdj = needsAdjust ? (immSel - XLen'(4)) : immSel;

    always_comb begin
        laneNext.valid = laneIn.valid;
        laneNext.kind  = kind;
        laneNext.imm   = immAdj;
    end

    // Result register.
    // Invalid lanes still load kind and imm.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            laneOut.valid <= 1'b0;
            laneOut.kind  <= laneNext.kind;
            laneOut.imm   <= laneNext.imm;
        end else begin
            laneOut <= laneNext;
        end
    end

endmodule

// File: logic/bundleSplitter.sv
module bundleSplitter (
    input  logic                                                       clk,
    input  logic                                                       rstN,
    input  logic                                                       bundleValid,
    input  logic [immDecodePkg::NumLanes-1:0]                          slotValid,
    input  logic [immDecodePkg::NumLanes-1:0][immDecodePkg::InstrWidth-1:0] bundle,
    output immDecodePkg::laneInT [immDecodePkg::NumLanes-1:0]          laneIn
);
    import immDecodePkg::*;

    // Per-lane qualified valid.
    // A slot only counts when the whole bundle is present.
    logic [NumLanes-1:0] qualValid;

    // Next-cycle lane records.
    laneInT [NumLanes-1:0] laneNext;

    assign qualValid = slotValid & {NumLanes{bundleValid}};

    // Pair each instruction with its qualified valid.
    always_comb begin
        for (int i = 0; i < NumLanes; i++) begin
            laneNext[i].valid = qualValid[i];
            laneNext[i].instr = bundle[i];
        end
    end

    // Bundle register.
    // Reset clears the valid bits only.
    // Instruction bits load from the input on every edge.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < NumLanes; i++) begin
                laneIn[i].valid <= 1'b0;
                laneIn[i].instr <= bundle[i];
            end
        end else begin
            laneIn <= laneNext;
        end
    end

endmodule

// File: common/immDecodePkg.sv
package immDecodePkg;

    // Datapath widths.
    localparam int XLen = 64;
    localparam int InstrWidth = 32;
    localparam int OpcodeWidth = 7;

    // Instructions per fetch bundle.
    localparam int NumLanes = 4;

    // Filled-slot count, wide enough for NumLanes.
    localparam int CountWidth = 3;

    // Immediate format selector.
    // One value per input of the lane's nine-way format select.
    typedef enum logic [3:0] {
        kindI     = 4'd0,
        kindS     = 4'd1,
        kindB     = 4'd2,
        kindJ     = 4'd3,
        kindAuipc = 4'd4,
        kindJalr  = 4'd5,
        kindLui   = 4'd6,
        kindFlw   = 4'd7,
        kindFsw   = 4'd8
    } immKindT;

    // Major opcodes, bits 6:0 of the instruction.
    localparam logic [OpcodeWidth-1:0] opLoad   = 7'b0000011;
    localparam logic [OpcodeWidth-1:0] opStore  = 7'b0100011;
    localparam logic [OpcodeWidth-1:0] opBranch = 7'b1100011;
    localparam logic [OpcodeWidth-1:0] opJal    = 7'b1101111;
    localparam logic [OpcodeWidth-1:0] opJalr   = 7'b1100111;
    localparam logic [OpcodeWidth-1:0] opAuipc  = 7'b0010111;
    localparam logic [OpcodeWidth-1:0] opLui    = 7'b0110111;
    localparam logic [OpcodeWidth-1:0] opFlw    = 7'b0000111;
    localparam logic [OpcodeWidth-1:0] opFsw    = 7'b0100111;

    // One instruction entering a lane.
    typedef struct packed {
        logic                  valid;
        logic [InstrWidth-1:0] instr;
    } laneInT;

    // One decoded immediate leaving a lane.
    typedef struct packed {
        logic            valid;
        immKindT         kind;
        logic [XLen-1:0] imm;
    } laneOutT;

endpackage
